/* list.f */
peri_pkg.sv
peri_addr_decode.sv
peri_read_buffer.sv
gpio_ctrl.sv
full_example_peri.sv
byte_example_peri.sv
tqv_peripherals.sv
tb_tqv_peripherals.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing -f list.f --top-module tb_tqv_peripherals -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "All tests passed!" sim.log; then
    echo "Simulation PASS"
    exit 0
fi
echo "Simulation FAIL"
exit 1

/* tb_tqv_peripherals.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tqv_peripherals;
    import peri_pkg::*;

    localparam int    RESET_CYCLES   = 10;
    localparam int    WAIT_LIMIT     = 16;   // Longest single access
    localparam int    MAX_ACCESSES   = 400;  // Bound over all tests, hold gaps included
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + MAX_ACCESSES * 8;
    localparam addr_t GPIO_BASE      = 11'h040;
    localparam addr_t FEX_BASE       = 11'h3C0;
    localparam addr_t BEX_BASE       = 11'h4F0;

    logic     clk;
    logic     rst_n;
    pins_t    ui_in;
    bus_req_t req;
    logic     read_complete;
    word_t    data_out;
    logic     data_ready;
    pins_t    uo_out;
    irq_t     user_irq;

    // Reference model state
    pins_t     m_gpio_out;
    func_sel_t m_fsel [NUM_PINS];
    word_t     m_fex;
    byte_t     m_bex [4];
    logic      m_irq;

    logic [31:0] lfsr;
    string       test_name;
    int          cycle_count = 0;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          checks;

    tqv_peripherals dut_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (ui_in),
        .i_req                (req),
        .i_data_read_complete (read_complete),
        .o_data_out           (data_out),
        .o_data_ready         (data_ready),
        .o_uo_out             (uo_out),
        .o_user_interrupts    (user_irq)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles, stuck in test %s", cycle_count, test_name);
            $display("Test failures found");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic acc_size_e rand_size();
        logic [1:0] code;
        code = 2'(rand_bits(2));
        return (code == 2'd3) ? ACC_WORD : acc_size_e'(code);
    endfunction

    // Any code of a slot that holds no peripheral
    function automatic func_sel_t empty_code();
        func_sel_t c;
        c = func_sel_t'(rand_bits(5));
        if (c[3:0] == 4'hF || c == 5'h01) c = 5'h00;
        return c;
    endfunction

    function automatic addr_t empty_addr();
        func_sel_t c;
        c = empty_code();
        if (c[4]) return {1'b1, 2'(rand_bits(2)), c[3:0], 4'(rand_bits(4))};
        return {1'b0, c[3:0], 6'(rand_bits(6))};
    endfunction

    function automatic addr_t fsel_addr(input int k);
        return GPIO_BASE + addr_t'(GPIO_FSEL_OFS) + addr_t'(4 * k);
    endfunction

    // Cycles from request to data ready, the full example answers a cycle later
    function automatic int read_latency(input addr_t a);
        return (!a[10] && a[9:6] == SLOT_FULL_EX) ? 2 : 1;
    endfunction

    function automatic pins_t slot_pins(input func_sel_t code);
        if (code == {1'b1, SLOT_BYTE_EX}) return m_bex[0];
        if (code == {1'b0, SLOT_GPIO}) return m_gpio_out;
        if (code == {1'b0, SLOT_FULL_EX}) return m_fex[7:0];
        return '0;  // Empty slot
    endfunction

    function automatic pins_t ref_pins();
        pins_t p;
        pins_t s;
        for (int k = 0; k < NUM_PINS; k++) begin
            s    = slot_pins(m_fsel[k]);
            p[k] = s[k];  // Same bit of the routed slot
        end
        return p;
    endfunction

    function automatic irq_t ref_irq();
        irq_t r;
        r = '0;
        r[$bits(irq_t)-1] = m_irq;  // Interrupt 15
        return r;
    endfunction

    function automatic word_t ref_read(input addr_t a);
        logic [5:0] ofs;
        ofs = a[5:0];
        if (a[10]) begin
            return (a[7:4] == SLOT_BYTE_EX && a[3:2] == 2'b00) ? word_t'(m_bex[a[1:0]]) : '0;
        end
        if (a[9:6] == SLOT_GPIO) begin
            if (ofs == GPIO_OUT_OFS) return word_t'(m_gpio_out);
            if (ofs == GPIO_IN_OFS) return word_t'(ui_in);
            if (ofs >= GPIO_FSEL_OFS && ofs[1:0] == 2'b00) return word_t'(m_fsel[ofs[4:2]]);
        end else if (a[9:6] == SLOT_FULL_EX) begin
            if (ofs == FEX_DATA_OFS) return m_fex;
            if (ofs == FEX_IN_OFS) return word_t'(ui_in);
        end
        return '0;
    endfunction

    function automatic void model_write(input addr_t a, input word_t d, input acc_size_e size);
        logic [5:0] ofs;
        ofs = a[5:0];
        if (a[10]) begin
            if (a[7:4] == SLOT_BYTE_EX && a[3:2] == 2'b00) m_bex[a[1:0]] = d[7:0];
        end else if (a[9:6] == SLOT_GPIO) begin
            if (ofs == GPIO_OUT_OFS) m_gpio_out = d[7:0];
            if (ofs >= GPIO_FSEL_OFS && ofs[1:0] == 2'b00) m_fsel[ofs[4:2]] = d[4:0];
        end else if (a[9:6] == SLOT_FULL_EX) begin
            if (ofs == FEX_DATA_OFS) begin
                case (size)
                    ACC_BYTE: m_fex[7:0]  = d[7:0];
                    ACC_HALF: m_fex[15:0] = d[15:0];
                    default:  m_fex       = d;
                endcase
                m_irq = 1'b1;
            end
            if (ofs == FEX_IRQ_CLR_OFS) m_irq = 1'b0;
        end
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pins(input string what, input pins_t exp, input pins_t act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_irq(input string what, input irq_t exp, input irq_t act);
        checks++;
        if (act !== exp) begin
            $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Error in %s: %s", test_name, msg);
        test_errors++;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        error_count += test_errors;
        if (test_errors == 0) begin
            $display("Test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("Test %s: FAILED with %0d errors", test_name, test_errors);
        end
    endtask

    // Write completes at the first rising edge with data ready
    task automatic bus_write(input addr_t a, input word_t d, input acc_size_e size);
        int waited;
        waited = 0;
        req = '{addr: a, wdata: d, wr_size: size, rd_size: ACC_NONE};
        @(posedge clk);
        while (!data_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!data_ready) begin
            report_failure($sformatf("write to %h never saw data ready", a));
        end else if (waited != 0) begin
            report_failure($sformatf("write to %h was not ready in its request cycle", a));
        end
        @(negedge clk);
        req.wr_size = ACC_NONE;
        model_write(a, d, size);
    endtask

    task automatic start_read(input addr_t a);
        req = '{addr: a, wdata: '0, wr_size: ACC_NONE, rd_size: ACC_WORD};
    endtask

    task automatic wait_ready(input int exp_cycles);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!data_ready && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!data_ready) begin
            report_failure($sformatf("read of %h never saw data ready", req.addr));
        end else if (waited + 1 != exp_cycles) begin
            report_failure($sformatf("read of %h took %0d cycles instead of %0d",
                                     req.addr, waited + 1, exp_cycles));
        end
    endtask

    task automatic finish_read();
        req.rd_size   = ACC_NONE;
        read_complete = 1'b1;
        @(negedge clk);
        read_complete = 1'b0;
    endtask

    task automatic read_check(input addr_t a);
        word_t exp;
        word_t got;
        exp = ref_read(a);
        start_read(a);
        wait_ready(read_latency(a));
        got = data_out;
        finish_read();
        check_word($sformatf("read of %h", a), exp, got);
    endtask

    initial begin
        word_t     first;
        int        hold_cycles;
        func_sel_t code;
        pins_t     empty_mask;
        addr_t     a;
        logic [1:0] pick;

        lfsr          = 32'h8faf_880b;
        rst_n         = 1'b0;
        ui_in         = '0;
        req           = '{addr: '0, wdata: '0, wr_size: ACC_NONE, rd_size: ACC_NONE};
        read_complete = 1'b0;
        m_gpio_out    = '0;
        m_fex         = '0;
        m_irq         = 1'b0;
        for (int k = 0; k < NUM_PINS; k++) m_fsel[k] = FSEL_RESET;
        for (int r = 0; r < 4; r++) m_bex[r] = '0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        checks       = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        start_test("reset_state");
        check_pins("uo_out", '0, uo_out);
        check_irq("user interrupts", '0, user_irq);
        if (data_ready !== 1'b0) report_failure("data ready is high after reset");
        for (int k = 0; k < NUM_PINS; k++) read_check(fsel_addr(k));
        read_check(GPIO_BASE);
        end_test();

        start_test("gpio");
        for (int i = 0; i < 8; i++) begin
            bus_write(GPIO_BASE, rand_bits(32), ACC_WORD);
            check_pins("uo_out after write", ref_pins(), uo_out);
            read_check(GPIO_BASE);
            ui_in = pins_t'(rand_bits(8));
            read_check(GPIO_BASE + addr_t'(GPIO_IN_OFS));
        end
        end_test();

        start_test("function_routing");
        for (int i = 0; i < 10; i++) begin
            bus_write(BEX_BASE, rand_bits(8), ACC_BYTE);
            bus_write(FEX_BASE, rand_bits(32), ACC_WORD);
            bus_write(GPIO_BASE, rand_bits(8), ACC_BYTE);
            empty_mask = '0;
            for (int k = 0; k < NUM_PINS; k++) begin
                pick = 2'(rand_bits(2));
                case (pick)
                    2'd0:    code = 5'h1F;
                    2'd1:    code = 5'h0F;
                    2'd2:    code = 5'h01;
                    default: begin
                        code          = empty_code();
                        empty_mask[k] = 1'b1;
                    end
                endcase
                bus_write(fsel_addr(k), word_t'(code), ACC_WORD);
            end
            check_pins("routed pins", ref_pins(), uo_out);
            check_pins("pins on empty slots", '0, uo_out & empty_mask);
            read_check(fsel_addr(int'(rand_bits(3))));
        end
        end_test();

        start_test("width_writes");
        bus_write(FEX_BASE, rand_bits(32), ACC_WORD);
        read_check(FEX_BASE);
        for (int i = 0; i < 8; i++) begin
            bus_write(FEX_BASE, rand_bits(32), rand_size());
            read_check(FEX_BASE);  // Merged value
        end
        read_check(FEX_BASE + addr_t'(FEX_IN_OFS));
        for (int r = 0; r < 4; r++) bus_write(BEX_BASE + addr_t'(r), rand_bits(8), ACC_BYTE);
        for (int r = 0; r < 16; r++) read_check(BEX_BASE + addr_t'(r));
        for (int i = 0; i < 8; i++) begin
            a = empty_addr();
            bus_write(a, rand_bits(32), ACC_WORD);
            read_check(a);
        end
        end_test();

        start_test("interrupt");
        bus_write(FEX_BASE + addr_t'(FEX_IRQ_CLR_OFS), rand_bits(32), ACC_WORD);
        check_irq("after first clear", ref_irq(), user_irq);
        for (int i = 0; i < 6; i++) begin
            bus_write(FEX_BASE, rand_bits(32), rand_size());
            check_irq("after data write", ref_irq(), user_irq);
            bus_write(FEX_BASE + addr_t'(FEX_IRQ_CLR_OFS), rand_bits(32), rand_size());
            check_irq("after clear", ref_irq(), user_irq);
        end
        end_test();

        start_test("read_hold");
        for (int i = 0; i < 5; i++) begin
            bus_write(FEX_BASE, rand_bits(32), ACC_WORD);
            start_read(FEX_BASE);
            wait_ready(read_latency(FEX_BASE));
            first = ref_read(FEX_BASE);
            check_word("first read", first, data_out);
            // New address and input while the result is still held
            req.addr    = GPIO_BASE + addr_t'(GPIO_IN_OFS);
            ui_in       = pins_t'(rand_bits(8));
            hold_cycles = 2 + int'(rand_bits(3));
            repeat (hold_cycles) begin
                @(negedge clk);
                check_word("held data", first, data_out);
            end
            finish_read();
            read_check(GPIO_BASE + addr_t'(GPIO_IN_OFS));
        end
        end_test();

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tqv_peripherals.sv */
`timescale 1ns/1ps
`default_nettype none

module tqv_peripherals (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire peri_pkg::pins_t        i_ui_in,
    input  wire peri_pkg::bus_req_t     i_req,
    input  wire                         i_data_read_complete,
    output peri_pkg::word_t             o_data_out,
    output logic                        o_data_ready,
    output peri_pkg::pins_t             o_uo_out,
    output peri_pkg::irq_t              o_user_interrupts
);
    import peri_pkg::*;

    bus_req_t                   req_masked;
    peri_resp_t                 sel_resp;
    bus_req_t [NUM_SLOTS-1:0]   user_req;
    slot_sel_t                  simple_wr;
    logic                       full_irq;

    // Driven per slot below
    wire peri_resp_t [NUM_SLOTS-1:0] user_resp;
    wire byte_t      [NUM_SLOTS-1:0] simple_data;
    wire pins_t      [NUM_SLOTS-1:0] user_pins;
    wire pins_t      [NUM_SLOTS-1:0] simple_pins;

    peri_read_buffer read_buf_i (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_req                (i_req),
        .i_resp               (sel_resp),
        .i_data_read_complete (i_data_read_complete),
        .o_req                (req_masked),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    peri_addr_decode decode_i (
        .i_req         (req_masked),
        .o_user_req    (user_req),
        .o_simple_wr   (simple_wr),
        .i_user_resp   (user_resp),
        .i_simple_data (simple_data),
        .o_resp        (sel_resp)
    );

    gpio_ctrl gpio_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_req         (user_req[SLOT_GPIO]),
        .i_ui_in       (i_ui_in),
        .o_resp        (user_resp[SLOT_GPIO]),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_gpio_pins   (user_pins[SLOT_GPIO]),
        .o_uo_out      (o_uo_out)
    );

    full_example_peri full_ex_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (user_req[SLOT_FULL_EX]),
        .i_ui_in (i_ui_in),
        .o_resp  (user_resp[SLOT_FULL_EX]),
        .o_pins  (user_pins[SLOT_FULL_EX]),
        .o_irq   (full_irq)
    );

    byte_example_peri byte_ex_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (simple_wr[SLOT_BYTE_EX]),
        .i_addr  (req_masked.addr[3:0]),
        .i_wdata (req_masked.wdata[7:0]),
        .o_rdata (simple_data[SLOT_BYTE_EX]),
        .o_pins  (simple_pins[SLOT_BYTE_EX])
    );

    // Empty slots read zero, answer at once and leave their pins low
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_empty
        if (s != SLOT_GPIO && s != SLOT_FULL_EX) begin : g_user
            assign user_resp[s] = '{rdata: '0, ready: 1'b1};
            assign user_pins[s] = '0;
        end
        if (s != SLOT_BYTE_EX) begin : g_simple
            assign simple_data[s] = '0;
            assign simple_pins[s] = '0;
        end
    end

    // Interrupt n of user slot n, vector starts at 2
    always_comb begin
        o_user_interrupts                   = '0;
        o_user_interrupts[SLOT_FULL_EX - 2] = full_irq;
    end

endmodule

`default_nettype wire

/* byte_example_peri.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_example_peri (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    i_wr,
    input  wire [3:0]              i_addr,
    input  wire peri_pkg::byte_t   i_wdata,
    output peri_pkg::byte_t        o_rdata,
    output peri_pkg::pins_t        o_pins
);
    import peri_pkg::*;

    byte_t regs [4];
    logic  in_range;

    assign in_range = i_addr[3:2] == 2'b00;  // Registers 0 to 3

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 4; r++) begin
                regs[r] <= '0;
            end
        end else if (i_wr && in_range) begin
            regs[i_addr[1:0]] <= i_wdata;
        end
    end

    assign o_rdata = in_range ? regs[i_addr[1:0]] : '0;

    // Register 0 drives the pads
    assign o_pins = regs[0];

endmodule

`default_nettype wire

/* full_example_peri.sv */
`timescale 1ns/1ps
`default_nettype none

module full_example_peri (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire peri_pkg::bus_req_t     i_req,
    input  wire peri_pkg::pins_t        i_ui_in,
    output peri_pkg::peri_resp_t        o_resp,
    output peri_pkg::pins_t             o_pins,
    output logic                        o_irq
);
    import peri_pkg::*;

    word_t      data_q;
    logic       irq_q;
    logic       ready_q;
    logic [5:0] ofs;

    assign ofs = i_req.addr[5:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q  <= '0;
            irq_q   <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (ofs == FEX_DATA_OFS) begin
                case (i_req.wr_size)
                    ACC_BYTE: data_q[7:0]  <= i_req.wdata[7:0];
                    ACC_HALF: data_q[15:0] <= i_req.wdata[15:0];
                    ACC_WORD: data_q       <= i_req.wdata;
                    default: ;
                endcase
                if (i_req.wr_size != ACC_NONE) begin
                    irq_q <= 1'b1;  // Any data write raises the interrupt
                end
            end
            if (ofs == FEX_IRQ_CLR_OFS && i_req.wr_size != ACC_NONE) begin
                irq_q <= 1'b0;
            end
            // Read answered one cycle later
            ready_q <= i_req.rd_size != ACC_NONE;
        end
    end

    always_comb begin
        o_resp.ready = ready_q;
        case (ofs)
            FEX_DATA_OFS: o_resp.rdata = data_q;
            FEX_IN_OFS:   o_resp.rdata = word_t'(i_ui_in);
            default:      o_resp.rdata = '0;
        endcase
    end

    assign o_pins = data_q[7:0];
    assign o_irq  = irq_q;

endmodule

`default_nettype wire

/* gpio_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
    input  wire                                          clk,
    input  wire                                          rst_n,
    input  wire peri_pkg::bus_req_t                      i_req,
    input  wire peri_pkg::pins_t                         i_ui_in,
    output peri_pkg::peri_resp_t                         o_resp,
    input  wire peri_pkg::pins_t [peri_pkg::NUM_SLOTS-1:0] i_user_pins,
    input  wire peri_pkg::pins_t [peri_pkg::NUM_SLOTS-1:0] i_simple_pins,
    output peri_pkg::pins_t                              o_gpio_pins,
    output peri_pkg::pins_t                              o_uo_out
);
    import peri_pkg::*;

    pins_t      gpio_out;
    func_sel_t  fsel [NUM_PINS];
    logic [5:0] ofs;
    logic       wr_active;
    logic       fsel_hit;
    logic [2:0] fsel_idx;

    assign ofs       = i_req.addr[5:0];
    assign wr_active = i_req.wr_size != ACC_NONE;

    // Select registers fill the upper half of the slot, one per word
    assign fsel_hit = (ofs[5:2] >= GPIO_FSEL_OFS[5:2]) && (ofs[1:0] == 2'b00);
    assign fsel_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int k = 0; k < NUM_PINS; k++) begin
                fsel[k] <= FSEL_RESET;
            end
        end else if (wr_active) begin
            if (ofs == GPIO_OUT_OFS) begin
                gpio_out <= i_req.wdata[7:0];
            end
            if (fsel_hit) begin
                fsel[fsel_idx] <= i_req.wdata[4:0];
            end
        end
    end

    always_comb begin
        o_resp.ready = 1'b1;
        if (ofs == GPIO_OUT_OFS) begin
            o_resp.rdata = word_t'(gpio_out);
        end else if (ofs == GPIO_IN_OFS) begin
            o_resp.rdata = word_t'(i_ui_in);
        end else if (fsel_hit) begin
            o_resp.rdata = word_t'(fsel[fsel_idx]);
        end else begin
            o_resp.rdata = '0;  // Unmapped offset
        end
    end

    // Each pad takes the same bit of the slot its select names
    always_comb begin
        for (int k = 0; k < NUM_PINS; k++) begin
            if (fsel[k][4]) begin
                o_uo_out[k] = i_simple_pins[fsel[k][3:0]][k];
            end else begin
                o_uo_out[k] = i_user_pins[fsel[k][3:0]][k];
            end
        end
    end

    assign o_gpio_pins = gpio_out;  // Looped back as user slot pins

endmodule

`default_nettype wire

/* peri_read_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module peri_read_buffer (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire peri_pkg::bus_req_t      i_req,
    input  wire peri_pkg::peri_resp_t    i_resp,
    input  wire                          i_data_read_complete,
    output peri_pkg::bus_req_t           o_req,
    output peri_pkg::word_t              o_data_out,
    output logic                         o_data_ready
);
    import peri_pkg::*;

    word_t data_q;
    logic  hold_q;
    logic  ready_q;
    logic  read_req;
    logic  write_req;
    logic  capture;

    assign read_req  = i_req.rd_size != ACC_NONE;
    assign write_req = i_req.wr_size != ACC_NONE;
    assign capture   = i_resp.ready && read_req && !hold_q;

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_resp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (capture) begin
                hold_q <= 1'b1;
            end else if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            ready_q <= read_req && i_resp.ready;  // Follows the data register
        end
    end

    // No second read toward the slots while the result is presented
    always_comb begin
        o_req = i_req;
        if (ready_q) begin
            o_req.rd_size = ACC_NONE;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || write_req;  // Writes finish in the request cycle

endmodule

`default_nettype wire

/* peri_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module peri_addr_decode (
    input  wire peri_pkg::bus_req_t                           i_req,
    output peri_pkg::bus_req_t   [peri_pkg::NUM_SLOTS-1:0]    o_user_req,
    output peri_pkg::slot_sel_t                               o_simple_wr,
    input  wire peri_pkg::peri_resp_t [peri_pkg::NUM_SLOTS-1:0] i_user_resp,
    input  wire peri_pkg::byte_t [peri_pkg::NUM_SLOTS-1:0]    i_simple_data,
    output peri_pkg::peri_resp_t                              o_resp
);
    import peri_pkg::*;

    logic  simple_bank;
    slot_t slot;

    assign simple_bank = i_req.addr[10];
    assign slot        = simple_bank ? i_req.addr[7:4] : i_req.addr[9:6];

    // Only the addressed user slot sees an active request
    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            o_user_req[s] = i_req;
            if (simple_bank || slot != slot_t'(s)) begin
                o_user_req[s].wr_size = ACC_NONE;
                o_user_req[s].rd_size = ACC_NONE;
            end
        end
    end

    always_comb begin
        o_simple_wr       = '0;
        o_simple_wr[slot] = simple_bank && (i_req.wr_size != ACC_NONE);
    end

    // Response of the addressed slot
    always_comb begin
        if (simple_bank) begin
            o_resp.rdata = word_t'(i_simple_data[slot]);
            o_resp.ready = 1'b1;  // Byte slots answer at once
        end else begin
            o_resp = i_user_resp[slot];
        end
    end

endmodule

`default_nettype wire

/* peri_pkg.sv */
`default_nettype none

package peri_pkg;

    typedef logic [10:0] addr_t;     // Peripheral address
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  pins_t;     // Eight pads
    typedef logic [3:0]  slot_t;     // Slot within a bank
    typedef logic [15:0] slot_sel_t; // One-hot over the 16 slots
    typedef logic [4:0]  func_sel_t; // [4] simple bank, [3:0] slot
    typedef logic [13:0] irq_t;      // User interrupts 2 to 15

    // Access size as sent by the core, 3 means idle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } acc_size_e;

    // Core request, held until data ready
    typedef struct packed {
        addr_t     addr;
        word_t     wdata;
        acc_size_e wr_size;
        acc_size_e rd_size;
    } bus_req_t;

    // Answer of one slot
    typedef struct packed {
        word_t rdata;
        logic  ready;
    } peri_resp_t;

    localparam int NUM_SLOTS = 16;
    localparam int NUM_PINS  = 8;

    // Occupied slots
    localparam slot_t SLOT_GPIO    = 4'd1;
    localparam slot_t SLOT_FULL_EX = 4'd15;
    localparam slot_t SLOT_BYTE_EX = 4'd15;  // Simple bank

    // GPIO register map, pin k select at GPIO_FSEL_OFS + 4k
    localparam logic [5:0] GPIO_OUT_OFS  = 6'h00;
    localparam logic [5:0] GPIO_IN_OFS   = 6'h04;
    localparam logic [5:0] GPIO_FSEL_OFS = 6'h20;

    // Full example register map
    localparam logic [5:0] FEX_DATA_OFS    = 6'h00;
    localparam logic [5:0] FEX_IN_OFS      = 6'h04;
    localparam logic [5:0] FEX_IRQ_CLR_OFS = 6'h08;

    localparam func_sel_t FSEL_RESET = 5'd1;  // All pins on GPIO

endpackage

`default_nettype wire
